// File: tests/spy_golden.txt
# op name bank offset value; bank is space bit and select (8 and up is status), value in hex
# I: offset is init cycles, value is the pointer read raised during init; C: offset is word count
I init_sweep 0 70 00000000
R init_b0_o0 0 0 0a0a0a0a
R init_b0_o31 0 31 0a0a0a0a
R init_b0_o63 0 63 0a0a0a0a
R init_b1_o0 1 0 0a0a0a0a
R init_b1_o31 1 31 0a0a0a0a
R init_b1_o63 1 63 0a0a0a0a
R init_b2_o0 2 0 0a0a0a0a
R init_b2_o31 2 31 0a0a0a0a
R init_b2_o63 2 63 0a0a0a0a
R init_b3_o0 3 0 0a0a0a0a
R init_b3_o31 3 31 0a0a0a0a
R init_b3_o63 3 63 0a0a0a0a
P init_b0_ptr 0 0 00000000
P init_b1_ptr 1 0 00000000
P init_b2_ptr 2 0 00000000
P init_b3_ptr 3 0 00000000
C cap_b1 1 5 5a3c9e10
R cap_b1_o0 1 0 5a3c9e10
P cap_b1_ptr 1 0 00000005
C wrap_b2 2 66 c7e1042a
R wrap_b2_o0 2 0 c7e1046a
R wrap_b2_o1 2 1 c7e1046b
R wrap_b2_o63 2 63 c7e10469
P wrap_b2_ptr 2 0 00000002
F freeze_b1_on 1 0 1
C frozen_cap 1 3 11110000
R frozen_o5 1 5 0a0a0a0a
P frozen_ptr 1 0 00000005
W wr_frozen 1 9 deadbeef
R rd_frozen 1 9 deadbeef
F freeze_b1_off 1 0 0
C resume_cap 1 2 3b8d55e0
R resume_o6 1 6 3b8d55e1
P resume_ptr 1 0 00000007
W wr_oor 5 3 12345678
R rd_oor 5 3 00000000
W wr_status 10 0 ffffffff
P status_ptr 2 0 00000002
I init_pending 2 70 00000000
R reinit_b2_o1 2 1 0a0a0a0a

// File: tb.f
verilog/spy_pkg.sv
verilog/spy_host_decode.sv
verilog/spy_buffer.sv
verilog/spy_readback.sv
verilog/spy_bank_top.sv
tests/spy_bank_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f tb.f --top-module spy_bank_tb \
   -Mdir obj_dir -o spy_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/spy_sim > sim.log 2>&1
grep -q "Some tests failed" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "All tests passed" sim.log || { echo "simulation ended early, see sim.log"; exit 1; }
echo "simulation passed"
exit 0

// File: tests/spy_bank_tb.sv
`timescale 1ns/100ps

module spy_bank_tb;

   localparam int num_buffers = 4;
   localparam int dw          = spy_pkg::spy_data_width;
   localparam int aw          = spy_pkg::spy_addr_width;
   localparam int ack_timeout = 50;                             // cycles allowed per handshake phase

   logic                      spy_clock   = 1'b0;
   logic                      axi_reset_n;
   logic [num_buffers*dw-1:0] mon_data;
   logic [num_buffers-1:0]    mon_vld;
   logic [num_buffers-1:0]    freeze;
   logic                      init_spy_mem;
   logic                      host_req;
   logic                      host_we;
   logic [aw-1:0]             host_addr;
   logic [dw-1:0]             host_wdata;
   logic                      host_ack;
   logic [dw-1:0]             host_rdata;
   logic                      init_busy;

   string       op_q[$];                                        // one golden file entry per op
   string       name_q[$];
   int          bank_q[$];
   int          offset_q[$];
   logic [31:0] value_q[$];
   int          op_count;
   bit          loaded      = 1'b0;
   int          seed        = 94;
   logic        req_at_edge;                                    // req as the DUT saw it
   logic        ack_seen    = 1'b0;

   spy_bank_top #(
      .num_buffers (num_buffers)
   ) dut (
      .spy_clock      (spy_clock),
      .axi_reset_n    (axi_reset_n),
      .mon_data_i     (mon_data),
      .mon_vld_i      (mon_vld),
      .freeze_i       (freeze),
      .init_spy_mem_i (init_spy_mem),
      .host_req_i     (host_req),
      .host_we_i      (host_we),
      .host_addr_i    (host_addr),
      .host_wdata_i   (host_wdata),
      .host_ack_o     (host_ack),
      .host_rdata_o   (host_rdata),
      .init_busy_o    (init_busy)
   );

   initial
   begin
      forever #2 spy_clock = ~spy_clock;                        // 4 ns period
   end

   task automatic report_fail();
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic stop_run(input string why);
      $display("%s", why);
      report_fail();
   endtask

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("Fail %s: expected %h, actual %h", name, expected, actual);
         report_fail();
      end
   endtask

   task automatic scramble_idle_lanes();
      for (int i = 0; i < num_buffers; i++)
      begin
         if (!mon_vld[i])
         begin
            mon_data[i*dw +: dw] = $random(seed);               // noise that is never captured
         end
      end
   endtask

   task automatic drive_request(input logic we, input logic [aw-1:0] addr,
                                input logic [31:0] wdata);
      @(negedge spy_clock);
      host_we    = we;
      host_addr  = addr;
      host_wdata = wdata;
      host_req   = 1'b1;                                        // everything held until ack
   endtask

   task automatic wait_ack(input string name);
      int waited;
      waited = 0;
      while (!host_ack)
      begin
         @(negedge spy_clock);
         waited++;
         if (waited > ack_timeout)
         begin
            stop_run($sformatf("%s: no ack within %0d cycles", name, ack_timeout));
         end
      end
      if (init_busy)
      begin
         stop_run($sformatf("%s: ack came while init was still running", name));
      end
   endtask

   task automatic close_request(input string name, output logic [31:0] rdata);
      int waited;
      rdata = host_rdata;
      @(negedge spy_clock);                                     // req still high so ack must stay
      check({name, " ack hold"}, 32'd1, {31'd0, host_ack});
      check({name, " rdata hold"}, rdata, host_rdata);
      host_req = 1'b0;
      waited   = 0;
      while (host_ack)
      begin
         @(negedge spy_clock);
         waited++;
         if (waited > ack_timeout)
         begin
            stop_run($sformatf("%s: ack stayed high after req fell", name));
         end
      end
   endtask

   task automatic host_access(input string name, input logic we, input logic [aw-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
      drive_request(we, addr, wdata);
      wait_ack(name);
      close_request(name, rdata);
   endtask

   // pointer read raised right after init starts and parked until the sweep ends
   task automatic run_init(input string name, input int bank, input int cycles,
                           input logic [31:0] expected);
      logic [31:0] rdata;
      @(negedge spy_clock);
      init_spy_mem = 1'b1;
      drive_request(1'b0, {1'b1, 3'(bank), 6'd0}, '0);
      repeat (cycles - 1)
      begin
         @(negedge spy_clock);
         check({name, " ack during init"}, 32'd0, {31'd0, host_ack});
      end
      check({name, " busy"}, 32'd1, {31'd0, init_busy});
      init_spy_mem = 1'b0;                                      // init high for cycles edges
      wait_ack(name);
      close_request(name, rdata);
      check(name, expected, rdata);
   endtask

   task automatic capture(input int bank, input int count, input logic [31:0] first);
      for (int k = 0; k < count; k++)
      begin
         @(negedge spy_clock);
         mon_vld[bank]           = 1'b1;
         mon_data[bank*dw +: dw] = first + 32'(k);              // counting run of words
         scramble_idle_lanes();
      end
      @(negedge spy_clock);
      mon_vld[bank] = 1'b0;
      scramble_idle_lanes();
   endtask

   task automatic set_freeze(input int bank, input logic on);
      @(negedge spy_clock);
      freeze[bank] = on;
   endtask

   task automatic load_golden();
      int          fd;
      int          got;
      int          fields;
      string       line;
      string       op;
      string       name;
      int          bank;
      int          offset;
      logic [31:0] value;
      fd = $fopen("tests/spy_golden.txt", "r");
      if (fd == 0)
      begin
         stop_run("cannot open tests/spy_golden.txt");
      end
      while (!$feof(fd))
      begin
         got = $fgets(line, fd);
         if (got > 0)
         begin
            fields = $sscanf(line, "%s %s %d %d %h", op, name, bank, offset, value);
            if (fields == 5)                                    // comments and blanks fall out here
            begin
               op_q.push_back(op);
               name_q.push_back(name);
               bank_q.push_back(bank);
               offset_q.push_back(offset);
               value_q.push_back(value);
            end
         end
      end
      $fclose(fd);
      op_count = op_q.size();
      loaded   = 1'b1;
   endtask

   task automatic run_line(input int i);
      logic [31:0]   rdata;
      logic [aw-1:0] addr;
      addr = {4'(bank_q[i]), 6'(offset_q[i])};                  // bank column is space and select
      case (op_q[i])
         "I": run_init(name_q[i], bank_q[i], offset_q[i], value_q[i]);
         "C": capture(bank_q[i], offset_q[i], value_q[i]);
         "F": set_freeze(bank_q[i], value_q[i][0]);
         "W": host_access(name_q[i], 1'b1, addr, value_q[i], rdata);
         "R":
         begin
            host_access(name_q[i], 1'b0, addr, '0, rdata);
            check(name_q[i], value_q[i], rdata);
         end
         "P":
         begin
            host_access(name_q[i], 1'b0, {1'b1, 3'(bank_q[i]), 6'd0}, '0, rdata);
            check(name_q[i], value_q[i], rdata);                // zero-extended pointer
         end
         default: stop_run($sformatf("unknown op %s in the golden file", op_q[i]));
      endcase
   endtask

   always @(posedge spy_clock)
   begin
      req_at_edge <= host_req;
   end

   // ack may only rise at an edge that saw req high
   always @(negedge spy_clock)
   begin
      if (host_ack && !ack_seen && !req_at_edge)
      begin
         stop_run("host_ack_o rose while host_req_i was low");
      end
      ack_seen = host_ack;
   end

   initial
   begin
      wait (loaded);
      repeat (op_count * 20 + 200) @(posedge spy_clock);
      stop_run($sformatf("watchdog: run still going after %0d cycles", op_count * 20 + 200));
   end

   initial
   begin
      axi_reset_n  = 1'b0;
      mon_data     = '0;
      mon_vld      = '0;
      freeze       = '0;
      init_spy_mem = 1'b0;
      host_req     = 1'b0;
      host_we      = 1'b0;
      host_addr    = '0;
      host_wdata   = '0;
      load_golden();
      repeat (8) @(negedge spy_clock);                          // 8 cycles of reset
      axi_reset_n = 1'b1;
      check("reset ack", 32'd0, {31'd0, host_ack});
      check("reset init busy", 32'd0, {31'd0, init_busy});
      for (int i = 0; i < op_count; i++)
      begin
         run_line(i);
      end
      repeat (4) @(negedge spy_clock);
      $display("All tests passed");
      $finish;
   end

endmodule

// File: verilog/spy_bank_top.sv
`timescale 1ns/100ps

module spy_bank_top #(
   parameter int num_buffers = 4                                // 1 to 8
)(
   input  logic                                           spy_clock,
   input  logic                                           axi_reset_n,
   input  logic [num_buffers*spy_pkg::spy_data_width-1:0] mon_data_i,  // word per buffer
   input  logic [num_buffers-1:0]                         mon_vld_i,
   input  logic [num_buffers-1:0]                         freeze_i,
   input  logic                                           init_spy_mem_i,
   input  logic                                           host_req_i,
   input  logic                                           host_we_i,
   input  logic [spy_pkg::spy_addr_width-1:0]             host_addr_i,
   input  logic [spy_pkg::spy_data_width-1:0]             host_wdata_i,
   output logic                                           host_ack_o,
   output logic [spy_pkg::spy_data_width-1:0]             host_rdata_o,
   output logic                                           init_busy_o
);

   localparam int dw = spy_pkg::spy_data_width;
   localparam int ow = spy_pkg::spy_offset_width;

   logic                                init_active;
   logic [ow-1:0]                       sweep_addr;
   logic                                acc_valid;
   logic                                acc_we;
   logic [num_buffers-1:0]              acc_hit;
   logic [ow-1:0]                       acc_offset;
   logic [dw-1:0]                       acc_wdata;
   logic                                rd_pend;
   logic                                acc_status;
   logic [spy_pkg::spy_sel_width-1:0]   acc_sel;
   logic [num_buffers*dw-1:0]           rd_data;      // packed buffer read words
   logic [num_buffers*ow-1:0]           wr_ptr;       // packed capture pointers

   spy_host_decode #(
      .num_buffers (num_buffers)
   ) u_decode (
      .spy_clock      (spy_clock),
      .axi_reset_n    (axi_reset_n),
      .init_spy_mem_i (init_spy_mem_i),
      .host_req_i     (host_req_i),
      .host_we_i      (host_we_i),
      .host_addr_i    (host_addr_i),                    // raw word into address union
      .host_wdata_i   (host_wdata_i),
      .ack_i          (host_ack_o),
      .init_active_o  (init_active),
      .sweep_addr_o   (sweep_addr),
      .acc_valid_o    (acc_valid),
      .acc_we_o       (acc_we),
      .acc_hit_o      (acc_hit),
      .acc_offset_o   (acc_offset),
      .acc_wdata_o    (acc_wdata),
      .rd_pend_o      (rd_pend),
      .acc_status_o   (acc_status),
      .acc_sel_o      (acc_sel)
   );

   generate
      for (genvar g = 0; g < num_buffers; g++)
      begin : g_buf
         spy_buffer u_buffer (
            .spy_clock     (spy_clock),
            .axi_reset_n   (axi_reset_n),
            .mon_data_i    (mon_data_i[g*dw +: dw]),
            .mon_vld_i     (mon_vld_i[g]),
            .freeze_i      (freeze_i[g]),
            .init_active_i (init_active),
            .sweep_addr_i  (sweep_addr),
            .acc_valid_i   (acc_valid),
            .acc_we_i      (acc_we),
            .acc_hit_i     (acc_hit[g]),               // own hit bit
            .acc_offset_i  (acc_offset),
            .acc_wdata_i   (acc_wdata),
            .rd_data_o     (rd_data[g*dw +: dw]),
            .wr_ptr_o      (wr_ptr[g*ow +: ow])
         );
      end
   endgenerate

   spy_readback #(
      .num_buffers (num_buffers)
   ) u_readback (
      .spy_clock    (spy_clock),
      .axi_reset_n  (axi_reset_n),
      .rd_pend_i    (rd_pend),
      .acc_status_i (acc_status),
      .acc_sel_i    (acc_sel),
      .rd_data_i    (rd_data),
      .wr_ptr_i     (wr_ptr),
      .host_req_i   (host_req_i),
      .host_ack_o   (host_ack_o),
      .host_rdata_o (host_rdata_o)
   );

   assign init_busy_o = init_active;                    // host sees sweep in progress

endmodule

// File: verilog/spy_readback.sv
`timescale 1ns/100ps

module spy_readback #(
   parameter int num_buffers = 4
)(
   input  logic                                             spy_clock,
   input  logic                                             axi_reset_n,
   input  logic                                             rd_pend_i,     // buffer data ready
   input  logic                                             acc_status_i,
   input  logic [spy_pkg::spy_sel_width-1:0]                acc_sel_i,
   input  logic [num_buffers*spy_pkg::spy_data_width-1:0]   rd_data_i,     // word per buffer
   input  logic [num_buffers*spy_pkg::spy_offset_width-1:0] wr_ptr_i,      // pointer per buffer
   input  logic                                             host_req_i,
   output logic                                             host_ack_o,
   output logic [spy_pkg::spy_data_width-1:0]               host_rdata_o
);

   localparam int dw = spy_pkg::spy_data_width;
   localparam int ow = spy_pkg::spy_offset_width;

   logic [dw-1:0] sel_word;

   always_comb
   begin
      sel_word = '0;                                            // unmapped select reads 0
      for (int i = 0; i < num_buffers; i++)
      begin
         if (int'(acc_sel_i) == i)
         begin
            if (acc_status_i)
            begin
               sel_word = {{(dw-ow){1'b0}}, wr_ptr_i[i*ow +: ow]}; // zero-extended pointer
            end
            else
            begin
               sel_word = rd_data_i[i*dw +: dw];
            end
         end
      end
   end

   always_ff @(posedge spy_clock)
   begin
      if (!axi_reset_n)
      begin
         host_ack_o <= 1'b0;
      end
      else if (rd_pend_i)
      begin
         host_ack_o <= 1'b1;                                    // access done
      end
      else if (!host_req_i)
      begin
         host_ack_o <= 1'b0;                                    // req gone so close handshake
      end
   end

   always_ff @(posedge spy_clock)
   begin
      if (rd_pend_i)
      begin
         host_rdata_o <= sel_word;                              // held until next access
      end
   end

   // read data must not move under a raised ack
   a_rdata_stable : assert property (@(posedge spy_clock) disable iff (!axi_reset_n)
      host_ack_o |=> (!host_ack_o || $stable(host_rdata_o)));

endmodule

// File: verilog/spy_buffer.sv
`timescale 1ns/100ps

module spy_buffer (
   input  logic                                 spy_clock,
   input  logic                                 axi_reset_n,
   input  logic [spy_pkg::spy_data_width-1:0]   mon_data_i,     // monitor stream word
   input  logic                                 mon_vld_i,
   input  logic                                 freeze_i,       // hold contents and pointer
   input  logic                                 init_active_i,
   input  logic [spy_pkg::spy_offset_width-1:0] sweep_addr_i,
   input  logic                                 acc_valid_i,
   input  logic                                 acc_we_i,
   input  logic                                 acc_hit_i,      // this buffer is selected
   input  logic [spy_pkg::spy_offset_width-1:0] acc_offset_i,
   input  logic [spy_pkg::spy_data_width-1:0]   acc_wdata_i,
   output logic [spy_pkg::spy_data_width-1:0]   rd_data_o,      // registered host read
   output logic [spy_pkg::spy_offset_width-1:0] wr_ptr_o        // next capture slot
);

   localparam int depth = 1 << spy_pkg::spy_offset_width;       // 64 words

   logic [spy_pkg::spy_data_width-1:0] mem [depth];
   logic                               capture;
   logic                               host_wr;
   logic                               host_rd;

   assign capture = mon_vld_i && !freeze_i && !init_active_i;
   assign host_wr = acc_valid_i && acc_hit_i && acc_we_i;
   assign host_rd = acc_valid_i && acc_hit_i && !acc_we_i;

   // circular capture pointer
   always_ff @(posedge spy_clock)
   begin
      if (!axi_reset_n)
      begin
         wr_ptr_o <= '0;
      end
      else if (init_active_i)
      begin
         wr_ptr_o <= '0;                                        // parked during sweep
      end
      else if (capture)
      begin
         wr_ptr_o <= wr_ptr_o + 1'b1;                           // wraps at 64 and advances even if host wins
      end
   end

   // one write port with sweep over host over capture
   always_ff @(posedge spy_clock)
   begin
      if (init_active_i)
      begin
         mem[sweep_addr_i] <= spy_pkg::spy_init_pattern;
      end
      else if (host_wr)
      begin
         mem[acc_offset_i] <= acc_wdata_i;                      // capture word lost this cycle
      end
      else if (capture)
      begin
         mem[wr_ptr_o] <= mon_data_i;
      end
   end

   // synchronous host read
   always_ff @(posedge spy_clock)
   begin
      if (host_rd)
      begin
         rd_data_o <= mem[acc_offset_i];
      end
   end

   // a frozen buffer outside init keeps its pointer across the edge
   a_freeze_holds_ptr : assert property (@(posedge spy_clock) disable iff (!axi_reset_n)
      (freeze_i && !init_active_i) |=> $stable(wr_ptr_o));

endmodule

// File: verilog/spy_host_decode.sv
`timescale 1ns/100ps

module spy_host_decode #(
   parameter int num_buffers = 4
)(
   input  logic                                 spy_clock,
   input  logic                                 axi_reset_n,
   input  logic                                 init_spy_mem_i,
   input  logic                                 host_req_i,
   input  logic                                 host_we_i,
   input  spy_pkg::spy_addr_u                   host_addr_i,
   input  logic [spy_pkg::spy_data_width-1:0]   host_wdata_i,
   input  logic                                 ack_i,          // ack from readback
   output logic                                 init_active_o,
   output logic [spy_pkg::spy_offset_width-1:0] sweep_addr_o,
   output logic                                 acc_valid_o,    // one pulse per request
   output logic                                 acc_we_o,
   output logic [num_buffers-1:0]               acc_hit_o,      // one-hot buffer hit
   output logic [spy_pkg::spy_offset_width-1:0] acc_offset_o,
   output logic [spy_pkg::spy_data_width-1:0]   acc_wdata_o,
   output logic                                 rd_pend_o,      // acc_valid one cycle later
   output logic                                 acc_status_o,
   output logic [spy_pkg::spy_sel_width-1:0]    acc_sel_o
);

   localparam logic [1:0] st_idle     = 2'd0;                   // waiting for req
   localparam logic [1:0] st_busy     = 2'd1;                   // access in flight
   localparam logic [1:0] st_wait_low = 2'd2;                   // acked and waiting for req low

   logic [1:0]             state;
   logic                   accept;
   logic                   is_status;
   logic                   in_range;
   logic [num_buffers-1:0] hit_dec;

   assign is_status = (host_addr_i.stat.space == spy_pkg::spy_space_status);
   assign in_range  = (int'(host_addr_i.mem.sel) < num_buffers);

   // also hold off when init is about to start so the sweep never meets an access
   assign accept = (state == st_idle) && host_req_i && !ack_i &&
                   !init_active_o && !init_spy_mem_i;

   always_comb
   begin
      for (int i = 0; i < num_buffers; i++)
      begin
         hit_dec[i] = !is_status && (int'(host_addr_i.mem.sel) == i); // out of range hits none
      end
   end

   always_ff @(posedge spy_clock)
   begin
      if (!axi_reset_n)
      begin
         state       <= st_idle;
         acc_valid_o <= 1'b0;
         rd_pend_o   <= 1'b0;
         acc_we_o    <= 1'b0;
         acc_hit_o   <= '0;
      end
      else
      begin
         acc_valid_o <= accept;                                 // single-cycle pulse
         rd_pend_o   <= acc_valid_o;                            // lines up with buffer read data
         case (state)
            st_idle:     state <= accept ? st_busy : st_idle;
            st_busy:     state <= ack_i ? st_wait_low : st_busy;
            st_wait_low: state <= host_req_i ? st_wait_low : st_idle;
            default:     state <= st_idle;
         endcase
         if (accept)
         begin
            acc_we_o  <= host_we_i && !is_status && in_range;   // status and unmapped writes dropped
            acc_hit_o <= hit_dec;
         end
      end
   end

   always_ff @(posedge spy_clock)
   begin
      if (accept)
      begin
         acc_offset_o <= host_addr_i.mem.offset;
         acc_wdata_o  <= host_wdata_i;
         acc_status_o <= is_status;
         acc_sel_o    <= host_addr_i.mem.sel;                   // same bits in both views
      end
   end

   always_ff @(posedge spy_clock)
   begin
      if (!axi_reset_n)
      begin
         init_active_o <= 1'b0;
         sweep_addr_o  <= '0;
      end
      else
      begin
         init_active_o <= init_spy_mem_i;                       // one cycle behind the request
         sweep_addr_o  <= (init_active_o && init_spy_mem_i) ? sweep_addr_o + 1'b1 : '0;
      end
   end

   // host traffic and the init sweep never share a cycle on the buffer write port
   a_no_acc_in_init : assert property (@(posedge spy_clock) disable iff (!axi_reset_n)
      acc_valid_o |-> !init_active_o);

endmodule

// File: verilog/spy_pkg.sv
package spy_pkg;

   localparam int spy_data_width   = 32;                   // monitor, memory and host words
   localparam int spy_offset_width = 6;                    // 64 words per buffer
   localparam int spy_sel_width    = 3;                    // at most 8 buffers
   localparam int spy_addr_width   = 1 + spy_sel_width + spy_offset_width; // host address word

   localparam logic [spy_data_width-1:0] spy_init_pattern = 32'h0a0a0a0a; // sweep fill word

   localparam logic spy_space_status = 1'b1;               // space bit of a status access

   // one host address word, seen as a memory access or as a status access
   typedef union packed
   {
      struct packed
      {
         logic                        space;              // 0 for memory space
         logic [spy_sel_width-1:0]    sel;                // buffer select
         logic [spy_offset_width-1:0] offset;             // word inside the buffer
      } mem;
      struct packed
      {
         logic                        space;              // 1 for status space
         logic [spy_sel_width-1:0]    sel;                // buffer whose pointer is read
         logic [spy_offset_width-1:0] reserved;           // ignored
      } stat;
   } spy_addr_u;

endpackage
